/* vlog.f */
mesh_pkg.sv
fwd_link_if.sv
mesh_router.sv
mem_bank.sv
io_host.sv
manycore_row.sv
manycore_row_checker.sv
tb_manycore_row.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the manycore row testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --top-module tb_manycore_row \
    -f vlog.f -o tb_manycore_row; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_manycore_row +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test OK" <<< "$out"; then
  exit 0
fi
exit 1

/* tb_manycore_row.sv */
/*
 * manycore row testbench
 * drives directed and random commands through the host port and
 * checks every response against a reference memory model
 */

`timescale 1ns/1ps

module tb_manycore_row;

  import mesh_pkg::*;

  localparam int num_random_lp     = 300;
  localparam int directed_max_lp   = 100;  // upper bound on directed commands
  // 20 cycles covers the slowest round trip to column 3
  localparam int timeout_cycles_lp = (num_random_lp + directed_max_lp) * 20 + 100;

  logic                     clk;
  logic                     reset_i;
  logic                     cmd_v_i;
  mesh_op_e                 cmd_op_i;
  logic [x_width_lp-1:0]    cmd_x_i;
  logic [addr_width_lp-1:0] cmd_addr_i;
  logic [data_width_lp-1:0] cmd_data_i;
  logic                     busy_o;
  logic                     resp_v_o;
  logic [data_width_lp-1:0] resp_data_o;

  logic [data_width_lp-1:0] model_mem [num_cols_lp][2**addr_width_lp];
  logic [data_width_lp-1:0] exp_q [$];  // one entry per accepted command
  string                    name_q [$];

  int errors      = 0;
  int checks      = 0;
  int accepted    = 0;
  int responses   = 0;
  int cycle_count = 0;

  manycore_row u_manycore_row (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_x_i     (cmd_x_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

  bind manycore_row manycore_row_checker u_checker (
    .clk      (clk),
    .reset_i  (reset_i),
    .busy_i   (busy_o),
    .resp_v_i (resp_v_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles_lp) begin
      $display("run timed out after %0d cycles with a command still pending", cycle_count);
      $display("Test FAILED");
      $finish;
    end
  end

  // bank rules: store echoes data, load returns word, fetch-add returns old word
  function automatic logic [data_width_lp-1:0] ref_access(
    input mesh_op_e                 op,
    input logic [x_width_lp-1:0]    x,
    input logic [addr_width_lp-1:0] addr,
    input logic [data_width_lp-1:0] data
  );
    logic [data_width_lp-1:0] old_word;
    logic [data_width_lp-1:0] result;
    old_word = model_mem[x][addr];
    result   = old_word;
    case (op)
      op_store: begin
        model_mem[x][addr] = data;
        result             = data;
      end
      op_amo_add: begin
        model_mem[x][addr] = old_word + data;  // 32-bit wrap
      end
      default: begin
        result = old_word;
      end
    endcase
    return result;
  endfunction

  function automatic mesh_op_e pick_op(input int unsigned r);
    mesh_op_e op;
    case (r % 3)
      0:       op = op_load;
      1:       op = op_store;
      default: op = op_amo_add;
    endcase
    return op;
  endfunction

  task automatic check_value(
    input string                    name,
    input logic [data_width_lp-1:0] expected,
    input logic [data_width_lp-1:0] actual
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // sample busy_o away from the rising edge
  task automatic wait_idle();
    @(negedge clk);
    while (busy_o) @(negedge clk);
  endtask

  task automatic send_cmd(
    input mesh_op_e                 op,
    input logic [x_width_lp-1:0]    x,
    input logic [addr_width_lp-1:0] addr,
    input logic [data_width_lp-1:0] data,
    input string                    name
  );
    wait_idle();
    @(posedge clk);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= op;
    cmd_x_i    <= x;
    cmd_addr_i <= addr;
    cmd_data_i <= data;
    exp_q.push_back(ref_access(op, x, addr, data));
    name_q.push_back(name);
    accepted++;
    @(posedge clk);  // host takes it on this edge
    cmd_v_i <= 1'b0;
  endtask

  task automatic do_access(
    input mesh_op_e                 op,
    input logic [x_width_lp-1:0]    x,
    input logic [addr_width_lp-1:0] addr,
    input logic [data_width_lp-1:0] data,
    input string                    name
  );
    send_cmd(op, x, addr, data, name);
    wait_idle();
  endtask

  // compare each response pulse with the oldest expected value
  always @(negedge clk) begin
    if (resp_v_o === 1'b1) begin
      responses++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("a response arrived with no command outstanding");
      end else begin
        check_value(name_q.pop_front(), exp_q.pop_front(), resp_data_o);
      end
    end
  end

  initial begin
    mesh_op_e                 op;
    logic [x_width_lp-1:0]    x;
    logic [addr_width_lp-1:0] addr;
    logic [data_width_lp-1:0] data;

    reset_i    = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = op_load;
    cmd_x_i    = '0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    for (int c = 0; c < num_cols_lp; c++) begin
      for (int a = 0; a < 2**addr_width_lp; a++) begin
        model_mem[c][a] = '0;
      end
    end
    void'($urandom(41771));

    repeat (2) @(posedge clk);
    reset_i <= 1'b0;

    // every word reads zero after reset
    for (int c = 0; c < num_cols_lp; c++) begin
      for (int a = 0; a < 2**addr_width_lp; a++) begin
        do_access(op_load, x_width_lp'(c), addr_width_lp'(a), '0, "reset load");
      end
    end

    for (int c = 0; c < num_cols_lp; c++) begin
      addr = addr_width_lp'(c * 3 + 1);
      data = $urandom();
      do_access(op_store, x_width_lp'(c), addr, data, "store echo");
      do_access(op_load, x_width_lp'(c), addr, '0, "load after store");
    end

    // fetch-add across the 2^32 boundary
    do_access(op_store, 2'd2, 4'd5, 32'hffff_fff0, "amo setup store");
    do_access(op_amo_add, 2'd2, 4'd5, 32'h0000_0025, "amo old word");
    do_access(op_load, 2'd2, 4'd5, '0, "load after amo");

    // same address in other columns stays untouched
    do_access(op_store, 2'd1, 4'd9, 32'ha5a5_0001, "isolation store");
    for (int c = 0; c < num_cols_lp; c++) begin
      do_access(op_load, x_width_lp'(c), 4'd9, '0, "isolation load");
    end

    // a store offered while busy must be dropped
    send_cmd(op_load, 2'd3, 4'd0, '0, "busy accepted load");
    @(posedge clk);
    cmd_v_i    <= 1'b1;
    cmd_op_i   <= op_store;
    cmd_x_i    <= 2'd3;
    cmd_addr_i <= 4'd0;
    cmd_data_i <= 32'hdead_beef;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (!busy_o) begin
      errors++;
      $display("busy_o fell while the ignored command was still offered");
    end
    @(posedge clk);
    cmd_v_i <= 1'b0;
    wait_idle();
    do_access(op_load, 2'd3, 4'd0, '0, "load after ignored store");

    for (int i = 0; i < num_random_lp; i++) begin
      op   = pick_op($urandom());
      x    = x_width_lp'($urandom_range(num_cols_lp - 1));
      addr = addr_width_lp'($urandom_range(2**addr_width_lp - 1));
      data = $urandom();
      do_access(op, x, addr, data, $sformatf("random %0d", i));
    end

    repeat (4) @(negedge clk);
    check_value("response count", accepted, responses);
    check_value("checker assertions", '0, u_manycore_row.u_checker.fail_count);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* manycore_row_checker.sv */
/*
 * manycore row protocol checker
 * response pulse and busy rules at the top-level ports
 */

`timescale 1ns/1ps

module manycore_row_checker (
  input logic clk,
  input logic reset_i,
  input logic busy_i,
  input logic resp_v_i
);

  int unsigned pulse_fails = 0;
  int unsigned busy_fails  = 0;
  int unsigned fall_fails  = 0;
  int unsigned reset_fails = 0;
  int unsigned fail_count;

  assign fail_count = pulse_fails + busy_fails + fall_fails + reset_fails;

  a_single_pulse: assert property (@(posedge clk) disable iff (reset_i)
    resp_v_i |=> !resp_v_i)
    else begin
      $error("resp_v_o stayed high for two cycles");
      pulse_fails++;
    end

  a_resp_while_busy: assert property (@(posedge clk) disable iff (reset_i)
    resp_v_i |-> busy_i)
    else begin
      $error("resp_v_o pulsed while busy_o was low");
      busy_fails++;
    end

  // host is idle again right after the response
  a_busy_falls: assert property (@(posedge clk) disable iff (reset_i)
    resp_v_i |=> !busy_i)
    else begin
      $error("busy_o still high the cycle after resp_v_o");
      fall_fails++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    reset_i |=> (!busy_i && !resp_v_i))
    else begin
      $error("busy_o or resp_v_o high during reset");
      reset_fails++;
    end

endmodule

/* manycore_row.sv */
/*
 * manycore row top level
 * host at column 0, a chain of four routers and one memory
 * bank below each router
 */

`timescale 1ns/1ps

module manycore_row (
  input  logic                               clk,
  input  logic                               reset_i,
  input  logic                               cmd_v_i,
  input  mesh_pkg::mesh_op_e                 cmd_op_i,
  input  logic [mesh_pkg::x_width_lp-1:0]    cmd_x_i,
  input  logic [mesh_pkg::addr_width_lp-1:0] cmd_addr_i,
  input  logic [mesh_pkg::data_width_lp-1:0] cmd_data_i,
  output logic                               busy_o,
  output logic                               resp_v_o,
  output logic [mesh_pkg::data_width_lp-1:0] resp_data_o
);

  import mesh_pkg::*;

  // link i enters router i, last one dangles off the east edge
  fwd_link_if req_link [num_cols_lp+1] ();

  logic [num_cols_lp:0]     resp_v;
  logic [data_width_lp-1:0] resp_data [num_cols_lp+1];

  // nothing comes back from beyond the last column
  assign resp_v[num_cols_lp]    = 1'b0;
  assign resp_data[num_cols_lp] = '0;

  io_host u_io_host (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_x_i     (cmd_x_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_data_i  (cmd_data_i),
    .busy_o      (busy_o),
    .req         (req_link[0]),
    .resp_v_i    (resp_v[0]),
    .resp_data_i (resp_data[0]),
    .resp_v_o    (resp_v_o),
    .resp_data_o (resp_data_o)
  );

  for (genvar i = 0; i < num_cols_lp; i++) begin : g_col
    logic                     bank_v;
    mesh_op_e                 bank_op;
    logic [addr_width_lp-1:0] bank_addr;
    logic [data_width_lp-1:0] bank_data;
    logic                     rd_v;
    logic [data_width_lp-1:0] rd_data;

    mesh_router u_router (
      .clk            (clk),
      .reset_i        (reset_i),
      .col_i          (x_width_lp'(i)),
      .west_req       (req_link[i]),
      .east_req       (req_link[i+1]),
      .bank_v_o       (bank_v),
      .bank_op_o      (bank_op),
      .bank_addr_o    (bank_addr),
      .bank_data_o    (bank_data),
      .bank_rd_v_i    (rd_v),
      .bank_rd_data_i (rd_data),
      .resp_v_i       (resp_v[i+1]),
      .resp_data_i    (resp_data[i+1]),
      .resp_v_o       (resp_v[i]),
      .resp_data_o    (resp_data[i])
    );

    mem_bank u_bank (
      .clk       (clk),
      .reset_i   (reset_i),
      .v_i       (bank_v),
      .op_i      (bank_op),
      .addr_i    (bank_addr),
      .data_i    (bank_data),
      .rd_v_o    (rd_v),
      .rd_data_o (rd_data)
    );
  end

endmodule

/* io_host.sv */
/*
 * host endpoint at column 0
 * takes one command at a time, launches it as a request beat
 * and hands back the response when it returns from the row
 */

`timescale 1ns/1ps

module io_host (
  input  logic                               clk,
  input  logic                               reset_i,

  input  logic                               cmd_v_i,
  input  mesh_pkg::mesh_op_e                 cmd_op_i,
  input  logic [mesh_pkg::x_width_lp-1:0]    cmd_x_i,
  input  logic [mesh_pkg::addr_width_lp-1:0] cmd_addr_i,
  input  logic [mesh_pkg::data_width_lp-1:0] cmd_data_i,
  output logic                               busy_o,

  fwd_link_if.tx                             req,

  input  logic                               resp_v_i,
  input  logic [mesh_pkg::data_width_lp-1:0] resp_data_i,
  output logic                               resp_v_o,
  output logic [mesh_pkg::data_width_lp-1:0] resp_data_o
);

  import mesh_pkg::*;

  typedef enum logic {
    host_idle,
    host_wait
  } host_state_e;

  host_state_e state_r;
  logic        accept;

  assign accept = (state_r == host_idle) & cmd_v_i;
  assign busy_o = (state_r == host_wait);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_r <= host_idle;
      req.v   <= 1'b0;
    end else begin
      req.v <= accept;  // single beat onto column 0
      unique case (state_r)
        host_idle: if (cmd_v_i) state_r <= host_wait;
        host_wait: if (resp_v_i) state_r <= host_idle;
        default:   state_r <= host_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req.op   <= cmd_op_i;
      req.x    <= cmd_x_i;
      req.addr <= cmd_addr_i;
      req.data <= cmd_data_i;
    end
  end

  // response leaves while still busy, idle again next cycle
  assign resp_v_o    = resp_v_i;
  assign resp_data_o = resp_data_i;

endmodule

/* mem_bank.sv */
/*
 * column memory bank
 * 16 words, performs store, load and fetch-add and answers
 * one cycle after the request with the returned word
 */

`timescale 1ns/1ps

module mem_bank (
  input  logic                               clk,
  input  logic                               reset_i,
  input  logic                               v_i,
  input  mesh_pkg::mesh_op_e                 op_i,
  input  logic [mesh_pkg::addr_width_lp-1:0] addr_i,
  input  logic [mesh_pkg::data_width_lp-1:0] data_i,
  output logic                               rd_v_o,
  output logic [mesh_pkg::data_width_lp-1:0] rd_data_o
);

  import mesh_pkg::*;

  logic [data_width_lp-1:0] mem_r [2**addr_width_lp];
  logic [data_width_lp-1:0] old_word;

  assign old_word = mem_r[addr_i];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rd_v_o <= 1'b0;
      for (int i = 0; i < 2**addr_width_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else begin
      rd_v_o <= v_i;
      if (v_i) begin
        unique case (op_i)
          op_store: begin
            mem_r[addr_i] <= data_i;
            rd_data_o     <= data_i;  // echo
          end
          op_load: begin
            rd_data_o <= old_word;
          end
          op_amo_add: begin
            mem_r[addr_i] <= old_word + data_i;  // wraps mod 2^32
            rd_data_o     <= old_word;
          end
          default: begin
            rd_data_o <= '0;
          end
        endcase
      end
    end
  end

endmodule

/* mesh_router.sv */
/*
 * row router
 * steers a request from the west either down to the local bank or
 * one hop east, and registers responses from the bank or from the
 * east onto the westward response output
 */

`timescale 1ns/1ps

module mesh_router (
  input  logic                               clk,
  input  logic                               reset_i,
  input  logic [mesh_pkg::x_width_lp-1:0]    col_i,

  fwd_link_if.rx                             west_req,
  fwd_link_if.tx                             east_req,

  output logic                               bank_v_o,
  output mesh_pkg::mesh_op_e                 bank_op_o,
  output logic [mesh_pkg::addr_width_lp-1:0] bank_addr_o,
  output logic [mesh_pkg::data_width_lp-1:0] bank_data_o,
  input  logic                               bank_rd_v_i,
  input  logic [mesh_pkg::data_width_lp-1:0] bank_rd_data_i,

  input  logic                               resp_v_i,
  input  logic [mesh_pkg::data_width_lp-1:0] resp_data_i,
  output logic                               resp_v_o,
  output logic [mesh_pkg::data_width_lp-1:0] resp_data_o
);

  import mesh_pkg::*;

  logic                     local_hit;
  logic                     east_v_r;
  mesh_op_e                 req_op_r;
  logic [x_width_lp-1:0]    req_x_r;
  logic [addr_width_lp-1:0] req_addr_r;
  logic [data_width_lp-1:0] req_data_r;

  assign local_hit = (west_req.x == col_i);

  // strobes, one per direction
  always_ff @(posedge clk) begin
    if (reset_i) begin
      bank_v_o <= 1'b0;
      east_v_r <= 1'b0;
    end else begin
      bank_v_o <= west_req.v & local_hit;
      east_v_r <= west_req.v & ~local_hit;
    end
  end

  // one payload register feeds both the bank and the east link
  always_ff @(posedge clk) begin
    if (west_req.v) begin
      req_op_r   <= west_req.op;
      req_x_r    <= west_req.x;
      req_addr_r <= west_req.addr;
      req_data_r <= west_req.data;
    end
  end

  assign bank_op_o   = req_op_r;
  assign bank_addr_o = req_addr_r;
  assign bank_data_o = req_data_r;

  assign east_req.v    = east_v_r;
  assign east_req.op   = req_op_r;
  assign east_req.x    = req_x_r;   // passed on unchanged
  assign east_req.addr = req_addr_r;
  assign east_req.data = req_data_r;

  // westward response, bank and east never fire together
  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else begin
      resp_v_o <= bank_rd_v_i | resp_v_i;
    end
  end

  always_ff @(posedge clk) begin
    if (bank_rd_v_i) begin
      resp_data_o <= bank_rd_data_i;
    end else if (resp_v_i) begin
      resp_data_o <= resp_data_i;
    end
  end

endmodule

/* fwd_link_if.sv */
/*
 * eastbound request link
 * one beat per valid strobe, no ready and no back-pressure
 */

`timescale 1ns/1ps

interface fwd_link_if;

  logic                               v;     // one-cycle strobe
  mesh_pkg::mesh_op_e                 op;
  logic [mesh_pkg::x_width_lp-1:0]    x;     // destination column
  logic [mesh_pkg::addr_width_lp-1:0] addr;
  logic [mesh_pkg::data_width_lp-1:0] data;

  modport tx (output v, op, x, addr, data);
  modport rx (input v, op, x, addr, data);

endinterface

/* mesh_pkg.sv */
/*
 * mesh package
 * network sizes, request field widths and the opcode
 * encoding shared by the host, routers and banks of the row
 */

package mesh_pkg;

  // one bank per column
  localparam int num_cols_lp = 4;

  // column coordinate carried by every request
  localparam int x_width_lp = 2;

  // word address inside a bank, 16 words
  localparam int addr_width_lp = 4;

  localparam int data_width_lp = 32;

  // request opcodes
  typedef enum logic [1:0] {
    op_load    = 2'b00,
    op_store   = 2'b01,
    op_amo_add = 2'b10  // fetch-add, returns old word
  } mesh_op_e;

endpackage
